//--- compile.f
+incdir+hw
hw/lsu_pkg.sv
hw/mem_req_if.sv
hw/mem_access.sv
hw/wb_master_fsm.sv
hw/bus_timeout_timer.sv
hw/lsu_top.sv
verification/wb_slave_model.sv
verification/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the LSU testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module lsu_tb --Mdir "$OBJ" \
    -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vlsu_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -x "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- verification/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb;

    localparam int NUM_TESTS    = 41;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_NS  = (NUM_TESTS * (`LSU_BUS_TIMEOUT + 10) + RESET_CYCLES) * 10;

    logic             clk;
    logic             rst;
    logic             req_valid;
    lsu_pkg::opcode_t req_op;
    lsu_pkg::addr_t   req_addr;
    lsu_pkg::word_t   req_wdata;
    lsu_pkg::except_t req_except;
    logic             busy;
    logic             resp_valid;
    lsu_pkg::word_t   resp_rdata;
    lsu_pkg::except_t resp_except;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    lsu_pkg::be_t     wb_sel;
    lsu_pkg::addr_t   wb_adr;
    lsu_pkg::word_t   wb_dat_w;
    lsu_pkg::word_t   wb_dat_r;
    logic             wb_ack;
    logic             wb_err;

    string            t_name      [NUM_TESTS];
    lsu_pkg::opcode_t t_op        [NUM_TESTS];
    lsu_pkg::addr_t   t_addr      [NUM_TESTS];
    lsu_pkg::word_t   t_wdata     [NUM_TESTS];
    lsu_pkg::except_t t_exc_in    [NUM_TESTS];
    lsu_pkg::word_t   t_exp_rdata [NUM_TESTS];
    lsu_pkg::except_t t_exp_exc   [NUM_TESTS];
    int               n_entries;
    int               cur;

    lsu_top DUT (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_except  (req_except),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .resp_except (resp_except),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_sel      (wb_sel),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .wb_err      (wb_err)
    );

    wb_slave_model u_slave (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_sel   (wb_sel),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err)
    );

    always #5 clk = ~clk;

    task automatic add_entry(input string name, input lsu_pkg::opcode_t op,
                             input lsu_pkg::addr_t addr, input lsu_pkg::word_t wdata,
                             input lsu_pkg::except_t exc_in, input lsu_pkg::word_t exp_rdata,
                             input lsu_pkg::except_t exp_exc);
        if (n_entries < NUM_TESTS) begin
            t_name[n_entries]      = name;
            t_op[n_entries]        = op;
            t_addr[n_entries]      = addr;
            t_wdata[n_entries]     = wdata;
            t_exc_in[n_entries]    = exc_in;
            t_exp_rdata[n_entries] = exp_rdata;
            t_exp_exc[n_entries]   = exp_exc;
        end
        n_entries++;
    endtask

    // Stores read back as zero; expected except is except_in plus adel, ades or bus.
    task automatic build_table();
        add_entry("sw_word",       `OP_SW,  32'h10, 32'h1234_5678, 8'h00, 32'h0, 8'h00);
        add_entry("lw_word",       `OP_LW,  32'h10, 32'h0, 8'h00, 32'h1234_5678, 8'h00);
        add_entry("sw_base_20",    `OP_SW,  32'h20, 32'ha1b2_c3d4, 8'h00, 32'h0, 8'h00);
        add_entry("sb_lane0",      `OP_SB,  32'h20, 32'hffff_ff11, 8'h00, 32'h0, 8'h00);
        add_entry("sb_lane1",      `OP_SB,  32'h21, 32'hffff_ff22, 8'h00, 32'h0, 8'h00);
        add_entry("sb_lane2",      `OP_SB,  32'h22, 32'hffff_ff33, 8'h00, 32'h0, 8'h00);
        add_entry("sb_lane3",      `OP_SB,  32'h23, 32'hffff_ff44, 8'h00, 32'h0, 8'h00);
        add_entry("lw_after_sb",   `OP_LW,  32'h20, 32'h0, 8'h00, 32'h4433_2211, 8'h00);
        add_entry("sw_base_24",    `OP_SW,  32'h24, 32'hdead_beef, 8'h00, 32'h0, 8'h00);
        add_entry("sh_lower",      `OP_SH,  32'h24, 32'hffff_8001, 8'h00, 32'h0, 8'h00);
        add_entry("lw_after_shl",  `OP_LW,  32'h24, 32'h0, 8'h00, 32'hdead_8001, 8'h00);
        add_entry("sh_upper",      `OP_SH,  32'h26, 32'h1234_fe7f, 8'h00, 32'h0, 8'h00);
        add_entry("lw_after_shu",  `OP_LW,  32'h24, 32'h0, 8'h00, 32'hfe7f_8001, 8'h00);
        add_entry("lb_off0",       `OP_LB,  32'h24, 32'h0, 8'h00, 32'h0000_0001, 8'h00);
        add_entry("lbu_off0",      `OP_LBU, 32'h24, 32'h0, 8'h00, 32'h0000_0001, 8'h00);
        add_entry("lb_off1",       `OP_LB,  32'h25, 32'h0, 8'h00, 32'hffff_ff80, 8'h00);
        add_entry("lbu_off1",      `OP_LBU, 32'h25, 32'h0, 8'h00, 32'h0000_0080, 8'h00);
        add_entry("lb_off2",       `OP_LB,  32'h26, 32'h0, 8'h00, 32'h0000_007f, 8'h00);
        add_entry("lbu_off2",      `OP_LBU, 32'h26, 32'h0, 8'h00, 32'h0000_007f, 8'h00);
        add_entry("lb_off3",       `OP_LB,  32'h27, 32'h0, 8'h00, 32'hffff_fffe, 8'h00);
        add_entry("lbu_off3",      `OP_LBU, 32'h27, 32'h0, 8'h00, 32'h0000_00fe, 8'h00);
        add_entry("lh_off0",       `OP_LH,  32'h24, 32'h0, 8'h00, 32'hffff_8001, 8'h00);
        add_entry("lhu_off0",      `OP_LHU, 32'h24, 32'h0, 8'h00, 32'h0000_8001, 8'h00);
        add_entry("lh_off2",       `OP_LH,  32'h26, 32'h0, 8'h00, 32'hffff_fe7f, 8'h00);
        add_entry("lhu_off2",      `OP_LHU, 32'h26, 32'h0, 8'h00, 32'h0000_fe7f, 8'h00);
        add_entry("lh_positive",   `OP_LH,  32'h20, 32'h0, 8'h00, 32'h0000_2211, 8'h00);
        add_entry("lw_mis1",       `OP_LW,  32'h21, 32'h0, 8'h00, 32'h0, 8'h02);
        add_entry("lw_mis2_exc",   `OP_LW,  32'h22, 32'h0, 8'h10, 32'h0, 8'h12);
        add_entry("lh_mis",        `OP_LH,  32'h25, 32'h0, 8'h00, 32'h0, 8'h02);
        add_entry("lhu_mis",       `OP_LHU, 32'h27, 32'h0, 8'h00, 32'h0, 8'h02);
        add_entry("sw_mis",        `OP_SW,  32'h22, 32'hcafe_f00d, 8'h00, 32'h0, 8'h01);
        add_entry("sh_mis",        `OP_SH,  32'h23, 32'h0000_beef, 8'h00, 32'h0, 8'h01);
        add_entry("lw_after_mis",  `OP_LW,  32'h20, 32'h0, 8'h00, 32'h4433_2211, 8'h00);
        add_entry("sw_exc_in",     `OP_SW,  32'h20, 32'h5555_5555, 8'h80, 32'h0, 8'h80);
        add_entry("lw_exc_in",     `OP_LW,  32'h20, 32'h0, 8'h40, 32'h0, 8'h40);
        add_entry("lw_after_exc",  `OP_LW,  32'h20, 32'h0, 8'h00, 32'h4433_2211, 8'h00);
        add_entry("lw_err_region", `OP_LW,  32'h1000, 32'h0, 8'h00, 32'h0, 8'h04);
        add_entry("sw_err_region", `OP_SW,  32'h1004, 32'h7777_7777, 8'h00, 32'h0, 8'h04);
        add_entry("lw_silent",     `OP_LW,  32'h2000, 32'h0, 8'h00, 32'h0, 8'h04);
        add_entry("op_not_mem",    6'h00,   32'h20, 32'h9999_9999, 8'h00, 32'h0, 8'h00);
        add_entry("lw_after_nmem", `OP_LW,  32'h20, 32'h0, 8'h00, 32'h4433_2211, 8'h00);
    endtask

    // Only a memory opcode without any address or upstream exception reaches the bus.
    function automatic bit expects_bus_cycle(input int idx);
        lsu_pkg::except_t other_exc;
        other_exc = t_exp_exc[idx] & ~(8'h01 << `EXC_BUS);
        return (other_exc == 8'h00) &&
               (t_op[idx] inside {`OP_LB, `OP_LH, `OP_LW, `OP_LBU,
                                  `OP_LHU, `OP_SB, `OP_SH, `OP_SW});
    endfunction

    task automatic run_entry(input int idx);
        do begin
            @(posedge clk);
            #1;
        end while (busy);
        req_valid  = 1'b1;
        req_op     = t_op[idx];
        req_addr   = t_addr[idx];
        req_wdata  = t_wdata[idx];
        req_except = t_exc_in[idx];
        @(posedge clk);  // Accepted at this edge.
        #1;
        req_valid = 1'b0;
        while (!resp_valid) begin
            @(posedge clk);
            #1;
        end
        assert (resp_rdata === t_exp_rdata[idx]) else begin
            $display("ERROR %s: rdata expected %08h, actual %08h",
                     t_name[idx], t_exp_rdata[idx], resp_rdata);
            $display("Test failed");
            $fatal(1, "load data mismatch");
        end
        assert (resp_except === t_exp_exc[idx]) else begin
            $display("ERROR %s: except expected %02h, actual %02h",
                     t_name[idx], t_exp_exc[idx], resp_except);
            $display("Test failed");
            $fatal(1, "exception vector mismatch");
        end
    endtask

    // Every open bus cycle belongs to the entry in flight and uses its word address.
    always @(negedge clk) begin
        if (!rst && wb_cyc) begin
            assert (expects_bus_cycle(cur)) else begin
                $display("Entry %s opened a bus cycle although it must not reach the bus",
                         t_name[cur]);
                $display("Test failed");
                $fatal(1, "unexpected bus cycle");
            end
            assert (wb_stb === 1'b1 && wb_adr === {t_addr[cur][31:2], 2'b00}) else begin
                $display("ERROR %s: wb_adr expected %08h, actual %08h with wb_stb %b",
                         t_name[cur], {t_addr[cur][31:2], 2'b00}, wb_adr, wb_stb);
                $display("Test failed");
                $fatal(1, "bus request mismatch");
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_op     = '0;
        req_addr   = '0;
        req_wdata  = '0;
        req_except = '0;
        n_entries  = 0;
        cur        = 0;
        build_table();
        assert (n_entries == NUM_TESTS) else begin
            $display("The stimulus table holds %0d entries instead of %0d", n_entries, NUM_TESTS);
            $display("Test failed");
            $fatal(1, "stimulus table size");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            cur = i;
            run_entry(i);
        end
        $display("Test completed successfully");
        $finish;
    end

    // Every entry gets room for a full bus timeout plus the handshake cycles.
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired because no response arrived from the DUT in time");
        $display("Test failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- verification/wb_slave_model.sv
`timescale 1ns/1ps

module wb_slave_model (
    input  logic           clk,
    input  logic           rst,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  lsu_pkg::be_t   wb_sel,
    input  lsu_pkg::addr_t wb_adr,
    input  lsu_pkg::word_t wb_dat_w,
    output lsu_pkg::word_t wb_dat_r,
    output logic           wb_ack,
    output logic           wb_err
);

    lsu_pkg::word_t mem [64];
    logic           in_mem;
    logic           in_err;
    logic           start;

    assign in_mem = (wb_adr[31:8] == 24'h000000);  // Bytes 0x0000 to 0x00FF.
    assign in_err = (wb_adr[31:8] == 24'h000010);  // Bytes 0x1000 to 0x10FF.
    assign start  = wb_cyc && wb_stb && !wb_ack && !wb_err;

    // Addresses outside both regions get no answer at all.
    always @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wb_err   <= 1'b0;
            wb_dat_r <= '0;
            for (int i = 0; i < 64; i++) begin
                mem[i] <= 32'h5eed_0000 | (32'(i) << 2);
            end
        end else begin
            wb_ack <= start && in_mem;
            wb_err <= start && in_err;
            if (start && in_mem) begin
                wb_dat_r <= mem[wb_adr[7:2]];
                if (wb_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel[b]) begin
                            mem[wb_adr[7:2]][8*b +: 8] <= wb_dat_w[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  lsu_pkg::opcode_t req_op,
    input  lsu_pkg::addr_t   req_addr,
    input  lsu_pkg::word_t   req_wdata,
    input  lsu_pkg::except_t req_except,
    output logic             busy,
    output logic             resp_valid,
    output lsu_pkg::word_t   resp_rdata,
    output lsu_pkg::except_t resp_except,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output lsu_pkg::be_t     wb_sel,
    output lsu_pkg::addr_t   wb_adr,
    output lsu_pkg::word_t   wb_dat_w,
    input  lsu_pkg::word_t   wb_dat_r,
    input  logic             wb_ack,
    input  logic             wb_err
);

    lsu_pkg::lsu_req_t req;
    lsu_pkg::except_t  mem_except;
    logic              timer_run;
    logic              timer_expired;

    mem_req_if mem_bus ();

    mem_access u_mem_access (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .mem        (mem_bus.fmt),
        .mem_rdata  (resp_rdata),
        .mem_except (mem_except)
    );

    wb_master_fsm u_wb_master_fsm (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_except    (req_except),
        .busy          (busy),
        .resp_valid    (resp_valid),
        .resp_except   (resp_except),
        .req           (req),
        .mem           (mem_bus.bus),
        .fmt_except    (mem_except),
        .timer_run     (timer_run),
        .timer_expired (timer_expired),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_sel        (wb_sel),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .wb_err        (wb_err)
    );

    bus_timeout_timer u_bus_timeout_timer (
        .clk     (clk),
        .rst     (rst),
        .run     (timer_run),
        .expired (timer_expired)
    );

endmodule

//--- hw/bus_timeout_timer.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module bus_timeout_timer (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic expired
);

    logic [`LSU_TIMER_W-1:0] count;

    // The counter restarts from zero for every bus cycle.
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            count <= '0;
        end else if (!expired) begin
            count <= count + 1'b1;
        end
    end

    assign expired = run && (count == `LSU_TIMER_W'(`LSU_BUS_TIMEOUT - 1));

    a_count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        count <= `LSU_TIMER_W'(`LSU_BUS_TIMEOUT - 1)
    );

endmodule

//--- hw/wb_master_fsm.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module wb_master_fsm (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  lsu_pkg::opcode_t  req_op,
    input  lsu_pkg::addr_t    req_addr,
    input  lsu_pkg::word_t    req_wdata,
    input  lsu_pkg::except_t  req_except,
    output logic              busy,
    output logic              resp_valid,
    output lsu_pkg::except_t  resp_except,
    output lsu_pkg::lsu_req_t req,
    mem_req_if.bus            mem,
    input  lsu_pkg::except_t  fmt_except,
    output logic              timer_run,
    input  logic              timer_expired,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output lsu_pkg::be_t      wb_sel,
    output lsu_pkg::addr_t    wb_adr,
    output lsu_pkg::word_t    wb_dat_w,
    input  lsu_pkg::word_t    wb_dat_r,
    input  logic              wb_ack,
    input  logic              wb_err
);

    lsu_pkg::bus_state_e state;
    lsu_pkg::bus_state_e state_next;
    logic                accept;
    logic                bus_done;
    logic                bus_fail;
    logic                bus_fail_q;
    lsu_pkg::word_t      rdata_q;

    assign busy       = (state != lsu_pkg::IDLE);
    assign resp_valid = (state == lsu_pkg::RESP);
    assign accept     = req_valid && !busy;

    // The bus cycle is open only while the formatted request is valid.
    assign wb_cyc   = (state == lsu_pkg::ACCESS) && mem.en;
    assign wb_stb   = wb_cyc;
    assign wb_we    = wb_cyc && (|mem.wen);
    assign wb_sel   = (|mem.wen) ? mem.wen : 4'b1111;  // Reads fetch the whole word.
    assign wb_adr   = mem.addr;
    assign wb_dat_w = mem.wdata;

    assign timer_run = wb_cyc;
    assign bus_done  = wb_cyc && (wb_ack || wb_err || timer_expired);
    assign bus_fail  = wb_err || (timer_expired && !wb_ack);

    always_comb begin
        state_next = state;
        case (state)
            lsu_pkg::IDLE: begin
                if (accept) begin
                    state_next = lsu_pkg::ACCESS;
                end
            end
            lsu_pkg::ACCESS: begin
                if (!mem.en || bus_done) begin
                    state_next = lsu_pkg::RESP;
                end
            end
            lsu_pkg::RESP: begin
                state_next = lsu_pkg::IDLE;
            end
            default: begin
                state_next = lsu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= lsu_pkg::IDLE;
            bus_fail_q <= 1'b0;
        end else begin
            state <= state_next;
            if (accept) begin
                bus_fail_q <= 1'b0;
            end else if (bus_done) begin
                bus_fail_q <= bus_fail;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.op        <= req_op;
            req.addr      <= req_addr;
            req.wdata     <= req_wdata;
            req.except_in <= req_except;
            rdata_q       <= '0;  // Loads without a bus cycle read as zero.
        end else if (wb_cyc && wb_ack) begin
            rdata_q <= wb_dat_r;
        end
    end

    assign mem.rdata = rdata_q;

    always_comb begin
        resp_except           = fmt_except;
        resp_except[`EXC_BUS] = fmt_except[`EXC_BUS] | bus_fail_q;
    end

    // A classic cycle stays open until ack, err or expiry ends it.
    a_cyc_held: assert property (
        @(posedge clk) disable iff (rst)
        (wb_cyc && !bus_done) |=> wb_cyc
    );

    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        (wb_cyc && !bus_done) |=> $stable({wb_we, wb_sel, wb_adr, wb_dat_w})
    );

endmodule

//--- hw/mem_access.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module mem_access (
    input  logic              clk,
    input  logic              rst,
    input  lsu_pkg::lsu_req_t req,
    mem_req_if.fmt            mem,
    output lsu_pkg::word_t    mem_rdata,
    output lsu_pkg::except_t  mem_except
);

    logic             is_load;
    logic             is_store;
    logic             adel;
    logic             ades;
    lsu_pkg::be_t     lane_be;
    lsu_pkg::word_t   lane_wdata;
    lsu_pkg::word_t   load_word;

    // Opcode decode and alignment checks.
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        adel     = 1'b0;
        ades     = 1'b0;
        case (req.op)
            `OP_LB, `OP_LBU: begin
                is_load = 1'b1;
            end
            `OP_LH, `OP_LHU: begin
                is_load = 1'b1;
                adel    = req.addr[0];
            end
            `OP_LW: begin
                is_load = 1'b1;
                adel    = |req.addr[1:0];
            end
            `OP_SB: begin
                is_store = 1'b1;
            end
            `OP_SH: begin
                is_store = 1'b1;
                ades     = req.addr[0];
            end
            `OP_SW: begin
                is_store = 1'b1;
                ades     = |req.addr[1:0];
            end
            default: begin
            end
        endcase
    end

    // Upstream exception bits are kept and the address errors are added.
    always_comb begin
        mem_except            = req.except_in;
        mem_except[`EXC_ADEL] = req.except_in[`EXC_ADEL] | adel;
        mem_except[`EXC_ADES] = req.except_in[`EXC_ADES] | ades;
    end

    assign mem.en = (is_load || is_store) && !(|mem_except);

    // Store lanes, little-endian.
    always_comb begin
        lane_be    = 4'b0000;
        lane_wdata = req.wdata;
        case (req.op)
            `OP_SB: begin
                lane_be    = 4'b0001 << req.addr[1:0];
                lane_wdata = {4{req.wdata[7:0]}};
            end
            `OP_SH: begin
                lane_be    = req.addr[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {2{req.wdata[15:0]}};
            end
            `OP_SW: begin
                lane_be    = 4'b1111;
            end
            default: begin
            end
        endcase
    end

    assign mem.wen   = mem.en ? lane_be : 4'b0000;
    assign mem.wdata = lane_wdata;
    assign mem.addr  = {req.addr[`LSU_ADDR_W-1:2], 2'b00};

    // The addressed lane is moved down to bit 0 before extension.
    assign load_word = mem.rdata >> {req.addr[1:0], 3'b000};

    always_comb begin
        mem_rdata = '0;
        if (!adel) begin
            case (req.op)
                `OP_LB:  mem_rdata = {{24{load_word[7]}}, load_word[7:0]};
                `OP_LBU: mem_rdata = {24'h000000, load_word[7:0]};
                `OP_LH:  mem_rdata = {{16{load_word[15]}}, load_word[15:0]};
                `OP_LHU: mem_rdata = {16'h0000, load_word[15:0]};
                `OP_LW:  mem_rdata = load_word;
                default: mem_rdata = '0;
            endcase
        end
    end

    // A flagged access must never reach the bus.
    a_no_en_with_except: assert property (
        @(posedge clk) disable iff (rst)
        mem.en |-> (req.except_in == '0)
                   && !(req.op inside {`OP_LW, `OP_SW} && req.addr[1:0] != 2'b00)
                   && !(req.op inside {`OP_LH, `OP_LHU, `OP_SH} && req.addr[0])
    );

    a_wen_only_on_store: assert property (
        @(posedge clk) disable iff (rst)
        (|mem.wen) |-> is_store
    );

endmodule

//--- hw/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;

    logic           en;      // Valid aligned access requested.
    lsu_pkg::be_t   wen;     // All zero for a read.
    lsu_pkg::addr_t addr;    // Word-aligned address.
    lsu_pkg::word_t wdata;   // Store data replicated over the lanes.
    lsu_pkg::word_t rdata;   // Raw bus word captured on ack.

    modport fmt (
        output en,
        output wen,
        output addr,
        output wdata,
        input  rdata
    );

    modport bus (
        input  en,
        input  wen,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

//--- hw/lsu_pkg.sv
`include "lsu_defs.svh"

package lsu_pkg;

    typedef logic [31:0]              word_t;
    typedef logic [`LSU_ADDR_W-1:0]   addr_t;
    typedef logic [3:0]               be_t;      // One bit per byte lane.
    typedef logic [5:0]               opcode_t;
    typedef logic [7:0]               except_t;

    // Request as held by the bus FSM for the duration of one access.
    typedef struct packed {
        opcode_t op;
        addr_t   addr;
        word_t   wdata;
        except_t except_in;
    } lsu_req_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } bus_state_e;

endpackage

//--- hw/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// MIPS primary opcodes of the memory instructions.
`define OP_LB   6'h20
`define OP_LH   6'h21
`define OP_LW   6'h23
`define OP_LBU  6'h24
`define OP_LHU  6'h25
`define OP_SB   6'h28
`define OP_SH   6'h29
`define OP_SW   6'h2B

// Bit positions in the 8-bit exception vector.
`define EXC_ADES 0
`define EXC_ADEL 1
`define EXC_BUS  2

// A bus cycle without ack is abandoned after this many cycles.
`define LSU_BUS_TIMEOUT 16
`define LSU_TIMER_W     5

`define LSU_ADDR_W 32

`endif
